// ==== Bender.yml ====
package:
  name: calculator

sources:
  - files:
      - source/calc_isa_pkg.sv
      - source/calc_pipe_pkg.sv
      - source/calc_issue.sv
      - source/calc_pipe_int.sv
      - source/calc_pipe_mul.sv
      - source/calc_completion.sv
      - source/calculator_top.sv
  - target: test
    files:
      - tb/calculator_assertions.sv
      - tb/tb_calculator.sv

// ==== source/calc_completion.sv ====
`default_nettype none

module calc_completion
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
(
  input  logic                                  clk_i
  , input  logic                                reset_i
  , input  logic                                flush_i
  , input  stage_rec_s                          stage_isd_i
  , input  dword_t                              int_data_i
  , input  dword_t                              mul_data_i
  , output fwd_slice_s [pipe_stage_els_lp:1]    fwd_slices_o
  , output commit_pkt_s                         commit_pkt_o
  , output wb_pkt_s                             wb_pkt_o
);

  stage_rec_s [pipe_stage_els_lp:0]   stage_n;
  stage_rec_s [pipe_stage_els_lp-1:0] stage_r;
  logic       [pipe_stage_els_lp:0]   poison_n;
  logic       [pipe_stage_els_lp-1:0] poison_r;
  dword_t     [pipe_stage_els_lp:1]   comp_n;
  dword_t     [pipe_stage_els_lp-1:1] comp_r;

  // New record enters at index 0 and the rest move down one
  assign stage_n = {stage_r, stage_isd_i};

  // Flush reaches everything that has not yet passed commit
  always_comb
  begin
    poison_n[0] = flush_i;
    for (int i = 1; i <= pipe_stage_els_lp; i++)
    begin
      poison_n[i] = poison_r[i-1] | (flush_i & (i <= commit_stage_lp));
    end
  end

  // Results join the completion pipe when their owning record gets there
  always_comb
  begin
    comp_n[1] = '0;
    for (int i = 2; i <= pipe_stage_els_lp; i++)
    begin
      comp_n[i] = comp_r[i-1];
    end
    if (stage_r[int_done_stage_lp].pipe_int_v)
    begin
      comp_n[int_done_stage_lp+1] = int_data_i;
    end
    if (stage_r[mul_done_stage_lp].pipe_mul_v)
    begin
      comp_n[mul_done_stage_lp+1] = mul_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      stage_r  <= '0;
      poison_r <= '0;
    end
    else
    begin
      stage_r  <= stage_n[pipe_stage_els_lp-1:0];
      poison_r <= poison_n[pipe_stage_els_lp-1:0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    comp_r <= comp_n[pipe_stage_els_lp-1:1];
  end

  // Forwarding taps on the next-state values
  // A multiply only becomes visible once its product has arrived
  always_comb
  begin
    for (int i = 1; i <= pipe_stage_els_lp; i++)
    begin
      fwd_slices_o[i].wb_v    = stage_n[i].v
                                & stage_n[i].irf_w_v
                                & ~poison_n[i]
                                & ((stage_n[i].pipe_int_v & (i > int_done_stage_lp))
                                   | (stage_n[i].pipe_mul_v & (i > mul_done_stage_lp)));
      fwd_slices_o[i].rd_addr = stage_n[i].rd_addr;
      fwd_slices_o[i].rd_data = comp_n[i];
    end
  end

  always_comb
  begin
    commit_pkt_o.v       = stage_r[commit_stage_lp].v & ~poison_r[commit_stage_lp];
    commit_pkt_o.pc      = stage_r[commit_stage_lp].pc;
    commit_pkt_o.rd_addr = stage_r[commit_stage_lp].rd_addr;
  end

  always_comb
  begin
    wb_pkt_o.rd_w_v  = stage_r[wb_stage_lp].v
                       & stage_r[wb_stage_lp].irf_w_v
                       & ~poison_r[wb_stage_lp];
    wb_pkt_o.rd_addr = stage_r[wb_stage_lp].rd_addr;
    wb_pkt_o.rd_data = comp_r[wb_stage_lp];
  end

endmodule

`default_nettype wire

// ==== source/calc_isa_pkg.sv ====
`default_nettype none

package calc_isa_pkg;

  // RV64 integer datapath widths
  localparam int dword_width_lp    = 64;
  localparam int reg_addr_width_lp = 5;
  localparam int vaddr_width_lp    = 39;

  // Shift amount is taken from the low bits of rs2
  localparam int shamt_width_lp = 6;

  typedef logic [dword_width_lp-1:0]    dword_t;
  typedef logic [reg_addr_width_lp-1:0] reg_addr_t;

  // Integer and multiply opcodes
  typedef enum logic [3:0]
  {
    e_op_nop  = 4'h0
    , e_op_add  = 4'h1
    , e_op_sub  = 4'h2
    , e_op_and  = 4'h3
    , e_op_or   = 4'h4
    , e_op_xor  = 4'h5
    , e_op_sll  = 4'h6
    , e_op_srl  = 4'h7
    , e_op_addi = 4'h8
    , e_op_mul  = 4'h9
  } calc_op_e;

endpackage

`default_nettype wire

// ==== source/calc_issue.sv ====
`default_nettype none

module calc_issue
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
(
  input  logic                                  clk_i
  , input  logic                                reset_i
  , input  dispatch_pkt_s                       dispatch_pkt_i
  , input  fwd_slice_s [pipe_stage_els_lp:1]    fwd_slices_i
  , output dispatch_pkt_s                       reservation_o
  , output stage_rec_s                          stage_isd_o
);

  dispatch_pkt_s reservation_n;
  dispatch_pkt_s reservation_r;

  logic int_op;
  logic mul_op;

  // Oldest slice first, so the youngest matching writer lands last
  function automatic dword_t bypass
    (input reg_addr_t addr
     , input dword_t data
     , input fwd_slice_s [pipe_stage_els_lp:1] slices
     );
    dword_t result;
    result = data;
    for (int i = pipe_stage_els_lp; i >= 1; i--)
    begin
      if (slices[i].wb_v && (slices[i].rd_addr == addr))
      begin
        result = slices[i].rd_data;
      end
    end
    // x0 is hardwired
    if (addr == '0)
    begin
      result = '0;
    end
    return result;
  endfunction

  // Replace stale operands with in-flight results
  always_comb
  begin
    reservation_n     = dispatch_pkt_i;
    reservation_n.rs1 = bypass(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1, fwd_slices_i);
    reservation_n.rs2 = bypass(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2, fwd_slices_i);
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      reservation_r <= '0;
    end
    else
    begin
      reservation_r <= reservation_n;
    end
  end

  assign reservation_o = reservation_r;

  // Pipe steering from the opcode
  always_comb
  begin
    int_op = dispatch_pkt_i.opcode inside {e_op_add, e_op_sub, e_op_and, e_op_or,
                                           e_op_xor, e_op_sll, e_op_srl, e_op_addi};
    mul_op = (dispatch_pkt_i.opcode == e_op_mul);
  end

  // Stage record enters stage 0 on the same edge as the reservation
  always_comb
  begin
    stage_isd_o.v          = dispatch_pkt_i.v & ~dispatch_pkt_i.poison;
    stage_isd_o.pc         = dispatch_pkt_i.pc;
    stage_isd_o.rd_addr    = dispatch_pkt_i.rd_addr;
    stage_isd_o.pipe_int_v = int_op;
    stage_isd_o.pipe_mul_v = mul_op;
    // No register write for x0 or for a nop
    stage_isd_o.irf_w_v    = dispatch_pkt_i.irf_w_v
                             & (dispatch_pkt_i.rd_addr != '0)
                             & (int_op | mul_op);
  end

endmodule

`default_nettype wire

// ==== source/calc_pipe_int.sv ====
`default_nettype none

module calc_pipe_int
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
(
  input  dispatch_pkt_s   reservation_i
  , output dword_t        data_o
);

  dword_t                    rs1;
  dword_t                    rs2;
  dword_t                    imm;
  logic [shamt_width_lp-1:0] shamt;

  assign rs1   = reservation_i.rs1;
  assign rs2   = reservation_i.rs2;
  assign imm   = reservation_i.imm;
  assign shamt = rs2[shamt_width_lp-1:0];

  // Single-cycle ALU, captured by the completion pipe at stage 1
  always_comb
  begin
    case (reservation_i.opcode)
      e_op_add:
      begin
        data_o = rs1 + rs2;
      end
      e_op_sub:
      begin
        data_o = rs1 - rs2;
      end
      e_op_and:
      begin
        data_o = rs1 & rs2;
      end
      e_op_or:
      begin
        data_o = rs1 | rs2;
      end
      e_op_xor:
      begin
        data_o = rs1 ^ rs2;
      end
      e_op_sll:
      begin
        data_o = rs1 << shamt;
      end
      e_op_srl:
      begin
        data_o = rs1 >> shamt;
      end
      e_op_addi:
      begin
        data_o = rs1 + imm;
      end
      // Nop and multiply produce nothing here
      default:
      begin
        data_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/calc_pipe_mul.sv ====
`default_nettype none

module calc_pipe_mul
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
(
  input  logic            clk_i
  , input  logic          reset_i
  , input  dispatch_pkt_s reservation_i
  , output dword_t        data_o
);

  dword_t rs1_r;
  dword_t rs2_r;
  dword_t product_r;

  // First stage: operand capture, held while no multiply is issued
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rs1_r <= '0;
      rs2_r <= '0;
    end
    else if (reservation_i.v && (reservation_i.opcode == e_op_mul))
    begin
      rs1_r <= reservation_i.rs1;
      rs2_r <= reservation_i.rs2;
    end
  end

  // Second stage: low half of the product
  always_ff @(posedge clk_i)
  begin
    product_r <= rs1_r * rs2_r;
  end

  assign data_o = product_r;

endmodule

`default_nettype wire

// ==== source/calc_pipe_pkg.sv ====
`default_nettype none

package calc_pipe_pkg;

  import calc_isa_pkg::*;

  // Depth of the stage, completion and poison pipelines
  localparam int pipe_stage_els_lp = 5;

  // Stage whose record owns each pipe's result
  localparam int int_done_stage_lp = 0;
  localparam int mul_done_stage_lp = 2;

  // Output taps
  localparam int commit_stage_lp = 2;
  localparam int wb_stage_lp     = 4;

  typedef struct packed
  {
    logic                      v;
    logic                      poison;
    logic [vaddr_width_lp-1:0] pc;
    calc_op_e                  opcode;
    reg_addr_t                 rd_addr;
    reg_addr_t                 rs1_addr;
    reg_addr_t                 rs2_addr;
    logic                      irf_w_v;
    dword_t                    rs1;
    dword_t                    rs2;
    dword_t                    imm;
  } dispatch_pkt_s;

  // Per-stage bookkeeping carried alongside the completion data
  typedef struct packed
  {
    logic                      v;
    logic [vaddr_width_lp-1:0] pc;
    reg_addr_t                 rd_addr;
    logic                      irf_w_v;
    logic                      pipe_int_v;
    logic                      pipe_mul_v;
  } stage_rec_s;

  typedef struct packed
  {
    logic      wb_v;
    reg_addr_t rd_addr;
    dword_t    rd_data;
  } fwd_slice_s;

  typedef struct packed
  {
    logic                      v;
    logic [vaddr_width_lp-1:0] pc;
    reg_addr_t                 rd_addr;
  } commit_pkt_s;

  typedef struct packed
  {
    logic      rd_w_v;
    reg_addr_t rd_addr;
    dword_t    rd_data;
  } wb_pkt_s;

endpackage

`default_nettype wire

// ==== source/calculator_top.sv ====
`default_nettype none

module calculator_top
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
(
  input  logic            clk_i
  , input  logic          reset_i
  , input  dispatch_pkt_s dispatch_pkt_i
  , input  logic          flush_i
  , output commit_pkt_s   commit_pkt_o
  , output wb_pkt_s       wb_pkt_o
);

  dispatch_pkt_s                    reservation_r;
  stage_rec_s                       stage_isd;
  fwd_slice_s [pipe_stage_els_lp:1] fwd_slices;
  dword_t                           int_data;
  dword_t                           mul_data;

  // Bypass and reservation register
  calc_issue i_issue
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.fwd_slices_i(fwd_slices)
     ,.reservation_o(reservation_r)
     ,.stage_isd_o(stage_isd)
     );

  // Integer pipe, 1 cycle
  calc_pipe_int i_pipe_int
    (.reservation_i(reservation_r)
     ,.data_o(int_data)
     );

  // Multiply pipe, 2 cycles
  calc_pipe_mul i_pipe_mul
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.reservation_i(reservation_r)
     ,.data_o(mul_data)
     );

  calc_completion i_completion
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(flush_i)
     ,.stage_isd_i(stage_isd)
     ,.int_data_i(int_data)
     ,.mul_data_i(mul_data)
     ,.fwd_slices_o(fwd_slices)
     ,.commit_pkt_o(commit_pkt_o)
     ,.wb_pkt_o(wb_pkt_o)
     );

endmodule

`default_nettype wire

// ==== tb.f ====
source/calc_isa_pkg.sv
source/calc_pipe_pkg.sv
source/calc_issue.sv
source/calc_pipe_int.sv
source/calc_pipe_mul.sv
source/calc_completion.sv
source/calculator_top.sv
tb/calculator_assertions.sv
tb/tb_calculator.sv

// ==== tb/calculator_assertions.sv ====
`default_nettype none

module calculator_assertions
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
(
  input  logic          clk_i
  , input  logic        reset_i
  , input  commit_pkt_s commit_pkt_i
  , input  wb_pkt_s     wb_pkt_i
);

  int unsigned fail_count = 0;

  // Reset empties every stage record
  silent_after_reset: assert property (@(posedge clk_i)
    reset_i |=> (!commit_pkt_i.v && !wb_pkt_i.rd_w_v))
  else
  begin
    fail_count++;
    $error("commit or writeback active in the cycle after reset");
  end

  // A committed packet is already past the flush window
  // Nops are issued with rd x0, so every other commit writes a register
  commit_then_wb: assert property (@(posedge clk_i) disable iff (reset_i)
    (commit_pkt_i.v && (commit_pkt_i.rd_addr != '0))
    |-> ##2 (wb_pkt_i.rd_w_v && (wb_pkt_i.rd_addr == $past(commit_pkt_i.rd_addr, 2))))
  else
  begin
    fail_count++;
    $error("valid commit was not followed by its writeback two cycles later");
  end

  no_x0_data: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_pkt_i.rd_w_v && (wb_pkt_i.rd_addr == '0)) |-> (wb_pkt_i.rd_data == '0))
  else
  begin
    fail_count++;
    $error("writeback to x0 carries non-zero data");
  end

endmodule

bind calculator_top calculator_assertions i_assertions
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.commit_pkt_i(commit_pkt_o)
   ,.wb_pkt_i(wb_pkt_o)
   );

`default_nettype wire

// ==== tb/tb_calculator.sv ====
`default_nettype none

module tb_calculator
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
();

  localparam int          clk_period_lp   = 40;
  localparam int          drive_delay_lp  = 2;
  // Cycles from dispatch to commit and to writeback
  localparam int          commit_delay_lp = 3;
  localparam int          wb_delay_lp     = 5;
  localparam logic [15:0] lfsr_seed_lp    = 16'd98;

  typedef struct
  {
    string     name;
    calc_op_e  op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    bit        v;
    bit        poison;
    bit        flush;
  } row_t;

  typedef struct
  {
    string       name;
    commit_pkt_s pkt;
  } exp_commit_t;

  typedef struct
  {
    string   name;
    wb_pkt_s pkt;
  } exp_wb_t;

  logic          clk_i = 1'b0;
  logic          reset_i;
  logic          flush_i;
  dispatch_pkt_s dispatch_pkt_i;
  commit_pkt_s   commit_pkt_o;
  wb_pkt_s       wb_pkt_o;

  row_t        table_q[$];
  exp_commit_t commit_q[$];
  exp_wb_t     wb_q[$];
  // Model view is current at dispatch
  // Register file view lags until writeback
  dword_t      model_regs[32];
  dword_t      arch_regs[32];
  logic [15:0] lfsr_state;
  bit          table_ready = 1'b0;
  int          commit_errors = 0;
  int          wb_errors = 0;

  calculator_top i_dut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.flush_i(flush_i)
     ,.commit_pkt_o(commit_pkt_o)
     ,.wb_pkt_o(wb_pkt_o)
     );

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic random_word(output dword_t value);
    value = '0;
    for (int i = 0; i < dword_width_lp; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[dword_width_lp-2:0], lfsr_state[0]};
    end
  endtask

  function automatic dword_t model_result(input calc_op_e op, input dword_t a,
                                          input dword_t b, input dword_t imm);
    case (op)
      e_op_add:  return a + b;
      e_op_sub:  return a - b;
      e_op_and:  return a & b;
      e_op_or:   return a | b;
      e_op_xor:  return a ^ b;
      e_op_sll:  return a << b[5:0];
      e_op_srl:  return a >> b[5:0];
      e_op_addi: return a + imm;
      e_op_mul:  return a * b;
      default:   return '0;
    endcase
  endfunction

  task automatic add_row(input string name, input calc_op_e op, input int rd,
                         input int rs1, input int rs2, input bit v = 1'b1,
                         input bit poison = 1'b0, input bit flush = 1'b0);
    row_t row;
    row.name   = name;
    row.op     = op;
    row.rd     = reg_addr_t'(rd);
    row.rs1    = reg_addr_t'(rs1);
    row.rs2    = reg_addr_t'(rs2);
    row.v      = v;
    row.poison = poison;
    row.flush  = flush;
    table_q.push_back(row);
  endtask

  task automatic build_table();
    // Every opcode on independent registers
    add_row("add_ind", e_op_add, 1, 2, 3);
    add_row("sub_ind", e_op_sub, 4, 5, 6);
    add_row("and_ind", e_op_and, 7, 8, 9);
    add_row("or_ind", e_op_or, 10, 11, 12);
    add_row("xor_ind", e_op_xor, 13, 14, 15);
    add_row("sll_ind", e_op_sll, 16, 17, 18);
    add_row("srl_ind", e_op_srl, 19, 20, 21);
    add_row("addi_ind", e_op_addi, 22, 23, 0);
    add_row("mul_ind", e_op_mul, 24, 25, 26);
    add_row("nop_ind", e_op_nop, 0, 0, 0);
    // Integer chains at distance 1 and 2
    add_row("dep_add", e_op_add, 1, 1, 4);
    add_row("dep_d1", e_op_sub, 2, 1, 7);
    add_row("dep_d2", e_op_xor, 3, 1, 2);
    add_row("dep_sll", e_op_sll, 5, 3, 2);
    add_row("dep_addi", e_op_addi, 5, 5, 0);
    add_row("dep_chain", e_op_add, 6, 5, 5);
    // Overlapping multiplies with consumers at distance 3
    add_row("mul_a", e_op_mul, 8, 6, 3);
    add_row("mul_b", e_op_mul, 9, 5, 6);
    add_row("mul_c", e_op_mul, 10, 1, 2);
    add_row("mul_use", e_op_add, 11, 8, 1);
    add_row("mul_use2", e_op_mul, 12, 9, 11);
    add_row("mul_use3", e_op_sub, 13, 10, 11);
    add_row("mul_gap", e_op_nop, 0, 0, 0);
    add_row("mul_use4", e_op_or, 14, 12, 13);
    // x0 as target and source
    add_row("x0_write", e_op_add, 0, 1, 2);
    add_row("x0_read", e_op_add, 15, 0, 3);
    add_row("x0_mul", e_op_mul, 0, 4, 5);
    add_row("x0_read2", e_op_or, 16, 0, 0);
    add_row("x0_addi", e_op_addi, 17, 0, 0);
    // Flush on fl_c kills fl_a, fl_b and fl_c
    add_row("pre_flush", e_op_add, 18, 1, 2);
    add_row("fl_a", e_op_add, 19, 18, 3);
    add_row("fl_b", e_op_mul, 20, 4, 5);
    add_row("fl_c", e_op_sub, 18, 6, 7, 1'b1, 1'b0, 1'b1);
    add_row("post_flush", e_op_add, 21, 18, 19);
    add_row("post_mul", e_op_xor, 22, 20, 21);
    add_row("poison_row", e_op_add, 23, 1, 2, 1'b1, 1'b1, 1'b0);
    add_row("invalid_row", e_op_add, 24, 1, 2, 1'b0, 1'b0, 1'b0);
    add_row("after_poison", e_op_add, 25, 23, 24);
    add_row("tail_mul", e_op_mul, 26, 25, 22);
    add_row("tail_gap1", e_op_nop, 0, 0, 0);
    add_row("tail_gap2", e_op_nop, 0, 0, 0);
    add_row("tail_use", e_op_add, 27, 26, 0);
  endtask

  task automatic dispatch_row(input int idx);
    row_t          row;
    dispatch_pkt_s pkt;
    dword_t        result;
    bit            killed;
    bit            writes;
    exp_commit_t   ec;
    exp_wb_t       ew;
    row = table_q[idx];
    killed = !row.v || row.poison || row.flush;
    // A flush also kills the two packets ahead of it
    for (int k = 1; k <= 2; k++)
    begin
      if ((idx + k < table_q.size()) && table_q[idx + k].flush)
      begin
        killed = 1'b1;
      end
    end
    pkt          = '0;
    pkt.v        = row.v;
    pkt.poison   = row.poison;
    pkt.pc       = vaddr_width_lp'(32'h1000 + 4 * idx);
    pkt.opcode   = row.op;
    pkt.rd_addr  = row.rd;
    pkt.rs1_addr = row.rs1;
    pkt.rs2_addr = row.rs2;
    pkt.irf_w_v  = (row.op != e_op_nop);
    random_word(pkt.imm);
    // Stale register file values that force forwarding
    pkt.rs1 = arch_regs[row.rs1];
    pkt.rs2 = arch_regs[row.rs2];
    result = model_result(row.op, model_regs[row.rs1], model_regs[row.rs2], pkt.imm);
    writes = !killed && (row.op != e_op_nop) && (row.rd != '0);
    if (writes)
    begin
      model_regs[row.rd] = result;
    end
    ec.name           = row.name;
    ec.pkt.v          = !killed;
    ec.pkt.pc         = pkt.pc;
    ec.pkt.rd_addr    = row.rd;
    ew.name           = row.name;
    ew.pkt.rd_w_v     = writes;
    ew.pkt.rd_addr    = row.rd;
    ew.pkt.rd_data    = result;
    commit_q.push_back(ec);
    wb_q.push_back(ew);
    dispatch_pkt_i = pkt;
    flush_i        = row.flush;
  endtask

  task automatic dispatch_idle();
    exp_commit_t ec;
    exp_wb_t     ew;
    ec.name = "idle";
    ec.pkt  = '0;
    ew.name = "idle";
    ew.pkt  = '0;
    commit_q.push_back(ec);
    wb_q.push_back(ew);
    dispatch_pkt_i = '0;
    flush_i        = 1'b0;
  endtask

  task automatic check_commit(input string name, input commit_pkt_s expected,
                              input commit_pkt_s actual);
    bit mismatch;
    mismatch = (actual.v !== expected.v);
    if (expected.v)
    begin
      mismatch = mismatch || (actual.pc !== expected.pc)
                 || (actual.rd_addr !== expected.rd_addr);
    end
    if (mismatch)
    begin
      commit_errors++;
      $display("error %s commit: expected v=%0b pc=%h rd=%0d, actual v=%0b pc=%h rd=%0d",
               name, expected.v, expected.pc, expected.rd_addr,
               actual.v, actual.pc, actual.rd_addr);
    end
  endtask

  task automatic check_wb(input string name, input wb_pkt_s expected, input wb_pkt_s actual);
    bit mismatch;
    mismatch = (actual.rd_w_v !== expected.rd_w_v);
    if (expected.rd_w_v)
    begin
      mismatch = mismatch || (actual.rd_addr !== expected.rd_addr)
                 || (actual.rd_data !== expected.rd_data);
    end
    if (mismatch)
    begin
      wb_errors++;
      $display("error %s writeback: expected w=%0b rd=%0d data=%h, actual w=%0b rd=%0d data=%h",
               name, expected.rd_w_v, expected.rd_addr, expected.rd_data,
               actual.rd_w_v, actual.rd_addr, actual.rd_data);
    end
  endtask

  initial
  begin
    exp_commit_t ec;
    exp_wb_t     ew;
    int          total_cycles;
    reset_i        = 1'b1;
    flush_i        = 1'b0;
    dispatch_pkt_i = '0;
    lfsr_state     = lfsr_seed_lp;
    build_table();
    table_ready = 1'b1;
    // Junk in the x0 register file slot that the DUT must read as zero
    model_regs[0] = '0;
    random_word(arch_regs[0]);
    arch_regs[0][0] = 1'b1;
    for (int r = 1; r < 32; r++)
    begin
      random_word(model_regs[r]);
      arch_regs[r] = model_regs[r];
    end
    total_cycles = table_q.size() + wb_delay_lp;
    repeat (3) @(posedge clk_i);
    #(drive_delay_lp);
    reset_i = 1'b0;
    for (int c = 0; c < total_cycles; c++)
    begin
      if (c < table_q.size())
      begin
        dispatch_row(c);
      end
      else
      begin
        dispatch_idle();
      end
      @(negedge clk_i);
      if (c >= commit_delay_lp)
      begin
        ec = commit_q.pop_front();
        check_commit(ec.name, ec.pkt, commit_pkt_o);
      end
      if (c >= wb_delay_lp)
      begin
        ew = wb_q.pop_front();
        check_wb(ew.name, ew.pkt, wb_pkt_o);
        // Register file takes the write at the end of this cycle
        if (ew.pkt.rd_w_v)
        begin
          arch_regs[ew.pkt.rd_addr] = ew.pkt.rd_data;
        end
      end
      @(posedge clk_i);
      #(drive_delay_lp);
    end
    $display("Errors: %0d commit, %0d writeback, %0d assertion",
             commit_errors, wb_errors, i_dut.i_assertions.fail_count);
    if ((commit_errors == 0) && (wb_errors == 0) && (i_dut.i_assertions.fail_count == 0))
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial
  begin
    wait (table_ready);
    #((table_q.size() + 20) * clk_period_lp);
    $display("Timeout: the test loop did not finish in the expected number of cycles");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
